/* hw/hex_blink.sv */
`timescale 1ns/10ps
`include "hex_settings.svh"

module hex_blink (
  input  logic     clk_i,
  input  logic     rst_i,

  hex_disp_if.blink disp
);

  // half-period length in clocks
  localparam int unsigned BLINK_CYCLES = `HEX_BLINK_CYCLES;
  // counter wide enough for 0 .. BLINK_CYCLES-1
  localparam int unsigned CNT_W = (BLINK_CYCLES > 1) ? $clog2(BLINK_CYCLES) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(BLINK_CYCLES - 1);

  logic [CNT_W-1:0] blink_cnt;
  logic             cnt_wrap;
  logic             blink_q;

  // last clock of the half-period
  assign cnt_wrap = (blink_cnt == CNT_LAST);

  // half-period counter, starts over on wrap
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      blink_cnt <= '0;
    end else if (cnt_wrap) begin
      blink_cnt <= '0;
    end else begin
      blink_cnt <= blink_cnt + 1'b1;
    end
  end

  // phase starts low, flips once per half-period
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      blink_q <= 1'b0;
    end else if (cnt_wrap) begin
      blink_q <= ~blink_q;
    end
  end

  assign disp.blink_on = blink_q;

endmodule

/* hw/hex_ctrl.sv */
`timescale 1ns/10ps

module hex_ctrl (
  input  logic        clk_i,
  input  logic        rst_i,

  // cpu write port with byte enables
  input  logic [31:0] wdata_i,
  input  logic [31:0] addr_i,
  input  logic [3:0]  be_i,
  input  logic        we_i,

  // seven-segment pins, all active low
  output logic [6:0]  seg_o,
  output logic [3:0]  an_o,

  // register readback
  output logic [31:0] out_o
);

  // display state between the blocks
  hex_disp_if disp_if ();

  // register file and readback
  hex_regs u_regs (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wdata_i (wdata_i),
    .addr_i  (addr_i),
    .be_i    (be_i),
    .we_i    (we_i),
    .out_o   (out_o),
    .disp    (disp_if.regs)
  );

  // slow blink phase
  hex_blink u_blink (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .disp  (disp_if.blink)
  );

  // digit multiplexing and decode
  hex_scan u_scan (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .disp  (disp_if.scan),
    .an_o  (an_o),
    .seg_o (seg_o)
  );

endmodule

/* hw/hex_disp_if.sv */
`timescale 1ns/10ps

// display state handed from the register block to the scanner
interface hex_disp_if;

  import hex_pkg::*;

  // current number, digit 0 in bits 3:0
  number_t    number;
  // per-digit enable, 1 = digit lit
  dig_mask_t  dig_en;
  // which digit blinks, out of range = none
  blink_sel_t blink_sel;
  // blink phase, low = blinking digit dark
  logic       blink_on;

  // register block owns the stored state
  modport regs (
    output number,
    output dig_en,
    output blink_sel
  );

  // blink timer owns the phase
  modport blink (
    output blink_on
  );

  // scanner only looks
  modport scan (
    input number,
    input dig_en,
    input blink_sel,
    input blink_on
  );

endinterface

/* hw/hex_pkg.sv */
package hex_pkg;

  // one hex digit
  typedef logic [3:0]  digit_t;
  // displayed number, digit 0 in the low nibble
  typedef logic [15:0] number_t;
  // per-digit enable, also used for the anode vector
  typedef logic [3:0]  dig_mask_t;
  // blink select, 0..3 picks a digit, anything else turns blink off
  typedef logic [7:0]  blink_sel_t;
  // active-low cathodes, bit 0 = a ... bit 6 = g
  typedef logic [6:0]  seg_t;

  // register map, addr bit 3 picks the register
  localparam int unsigned REG_SEL_BIT = 3;
  typedef enum logic {
    REG_NUMBER  = 1'b0,
    REG_CONTROL = 1'b1
  } reg_sel_t;

  // all segments off
  localparam seg_t SEG_BLANK = 7'h7F;
  // selection loaded by a clear command, no digit blinks
  localparam blink_sel_t BLINK_NONE = 8'hFF;

  // standard hex glyphs, active low, pattern read as gfedcba
  function automatic seg_t hex_to_seg(digit_t d);
    seg_t s;
    case (d)
      4'h0:    s = 7'h40;
      4'h1:    s = 7'h79;
      4'h2:    s = 7'h24;
      4'h3:    s = 7'h30;
      4'h4:    s = 7'h19;
      4'h5:    s = 7'h12;
      4'h6:    s = 7'h02;
      4'h7:    s = 7'h78;
      4'h8:    s = 7'h00;
      4'h9:    s = 7'h10;
      4'hA:    s = 7'h08;
      4'hB:    s = 7'h03;
      4'hC:    s = 7'h46;
      4'hD:    s = 7'h21;
      4'hE:    s = 7'h06;
      default: s = 7'h0E;
    endcase
    return s;
  endfunction

endpackage

/* hw/hex_regs.sv */
`timescale 1ns/10ps

module hex_regs (
  input  logic        clk_i,
  input  logic        rst_i,

  input  logic [31:0] wdata_i,
  input  logic [31:0] addr_i,
  input  logic [3:0]  be_i,
  input  logic        we_i,

  output logic [31:0] out_o,

  hex_disp_if.regs    disp
);

  import hex_pkg::*;

  // stored register state
  number_t    number_q;
  dig_mask_t  dig_en_q;
  blink_sel_t blink_sel_q;

  // decoded write
  reg_sel_t   reg_sel;
  logic       ctrl_we;
  logic       clr_cmd;

  // only addr bit 3 matters, rest of the address is don't care
  assign reg_sel = reg_sel_t'(addr_i[REG_SEL_BIT]);

  // write strobe aimed at the control word
  assign ctrl_we = we_i && (reg_sel == REG_CONTROL);

  // clear = lane 2 of the control word with a nonzero byte
  assign clr_cmd = ctrl_we && be_i[2] && (wdata_i[23:16] != 8'h00);

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      number_q    <= '0;
      dig_en_q    <= '0;
      blink_sel_q <= '0;
    end else if (clr_cmd) begin
      // clear wins over the other lanes of the same write
      number_q    <= '0;
      dig_en_q    <= '1;
      blink_sel_q <= BLINK_NONE;
    end else if (we_i) begin
      if (reg_sel == REG_NUMBER) begin
        // lane 0 -> digits 0 and 1
        if (be_i[0]) begin
          number_q[7:0] <= wdata_i[7:0];
        end
        // lane 1 -> digits 2 and 3
        if (be_i[1]) begin
          number_q[15:8] <= wdata_i[15:8];
        end
      end else begin
        // lane 0 carries the digit enable
        if (be_i[0]) begin
          dig_en_q <= wdata_i[3:0];
        end
        // lane 1 carries the blink select
        if (be_i[1]) begin
          blink_sel_q <= wdata_i[15:8];
        end
        // lanes 2/3 with zero data do nothing
      end
    end
  end

  // readback, combinational on the address
  always_comb begin
    case (reg_sel)
      REG_CONTROL: out_o = {16'h0000, blink_sel_q, 4'h0, dig_en_q};
      default:     out_o = {16'h0000, number_q};
    endcase
  end

  // hand the state to the scanner
  assign disp.number    = number_q;
  assign disp.dig_en    = dig_en_q;
  assign disp.blink_sel = blink_sel_q;

endmodule

/* hw/hex_scan.sv */
`timescale 1ns/10ps
`include "hex_settings.svh"

module hex_scan (
  input  logic               clk_i,
  input  logic               rst_i,

  hex_disp_if.scan           disp,

  output hex_pkg::dig_mask_t an_o,
  output hex_pkg::seg_t      seg_o
);

  import hex_pkg::*;

  // refresh counter width, top two bits select the digit
  localparam int unsigned REF_BITS = `HEX_REFRESH_BITS;

  logic [REF_BITS-1:0] refresh_cnt;
  logic [1:0]          dig_idx;
  digit_t              cur_digit;
  logic                blink_hit;
  logic                dig_blank;
  dig_mask_t           an_next;
  seg_t                seg_next;

  // free running, wraps through all four digits
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      refresh_cnt <= '0;
    end else begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  // digit order 0,1,2,3
  assign dig_idx = refresh_cnt[REF_BITS-1 -: 2];

  // nibble of the active digit
  assign cur_digit = disp.number[{dig_idx, 2'b00} +: 4];

  // selected digit goes dark in the low blink phase
  // selects above 3 never match
  assign blink_hit = (disp.blink_sel == blink_sel_t'(dig_idx)) && !disp.blink_on;

  // disabled or blinked out
  assign dig_blank = !disp.dig_en[dig_idx] || blink_hit;

  // common anode, active digit pulled low
  assign an_next = ~(dig_mask_t'(1) << dig_idx);

  // cathode pattern for the active digit
  always_comb begin
    if (dig_blank) begin
      seg_next = SEG_BLANK;
    end else begin
      seg_next = hex_to_seg(cur_digit);
    end
  end

  // anode and cathodes registered on the same edge
  // so one never leads the other by a digit
  // display trails the register state by one clock
  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      // nothing lit until the first slot
      an_o  <= '1;
      seg_o <= SEG_BLANK;
    end else begin
      an_o  <= an_next;
      seg_o <= seg_next;
    end
  end

endmodule

/* hw/hex_settings.svh */
`ifndef HEX_SETTINGS_SVH
`define HEX_SETTINGS_SVH

// timing constants for the hex display controller
// values below are the simulation ones

// width of the free-running refresh counter
// top two bits pick the active digit
// each digit stays on for 2**(bits-2) clocks
// board build at 100 MHz uses 18
`define HEX_REFRESH_BITS 6

// clocks per blink half-period
// blink phase toggles once per wrap of the blink counter
// board build at 100 MHz uses 50000000 (half a second)
`define HEX_BLINK_CYCLES 200

// the refresh counter must hold at least the two digit-select bits
// and the blink counter must count at least one clock
// so keep HEX_REFRESH_BITS >= 2 and HEX_BLINK_CYCLES >= 1

// both values are used by the scanner and the blink timer
// and also by the testbench watchdog

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# build the hex display testbench with verilator and run it
# the log decides pass or fail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_hex_ctrl -f sim.f -o tb_hex_ctrl \
  && ./obj_dir/tb_hex_ctrl > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -qx "Verification passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim.f */
+incdir+hw
hw/hex_pkg.sv
hw/hex_disp_if.sv
hw/hex_regs.sv
hw/hex_blink.sv
hw/hex_scan.sv
hw/hex_ctrl.sv
test/hex_checker.sv
test/tb_hex_ctrl.sv

/* test/hex_checker.sv */
`timescale 1ns/10ps
`include "hex_settings.svh"

// watches the DUT pins, mirrors the registers and checks the display
module hex_checker (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic [31:0]        wdata_i,
  input  logic [31:0]        addr_i,
  input  logic [3:0]         be_i,
  input  logic               we_i,
  input  hex_pkg::seg_t      dut_seg_i,
  input  hex_pkg::dig_mask_t dut_an_i,
  output int                 err_cnt_o,
  output int                 cmp_cnt_o
);

  import hex_pkg::*;

  localparam logic [63:0] SLOT_CYCLES  = 64'(2 ** (`HEX_REFRESH_BITS - 2));
  localparam logic [63:0] BLINK_CYCLES = 64'(`HEX_BLINK_CYCLES);

  // shadow state and its copy from one clock earlier
  number_t     sh_number, prev_number;
  dig_mask_t   sh_en, prev_en;
  blink_sel_t  sh_sel, prev_sel;
  // clocks since reset release
  logic [63:0] edge_cnt;
  int          err_cnt = 0;
  int          cmp_cnt = 0;

  assign err_cnt_o = err_cnt;
  assign cmp_cnt_o = cmp_cnt;

  // active-low glyphs 0..F read as gfedcba
  function automatic seg_t glyph_of(input digit_t d);
    case (d)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'hA:    return 7'h08;
      4'hB:    return 7'h03;
      4'hC:    return 7'h46;
      4'hD:    return 7'h21;
      4'hE:    return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // expected cathodes of one digit for a given register state
  function automatic seg_t expected_seg(input number_t num, input dig_mask_t en,
                                        input blink_sel_t sel, input logic blink_on,
                                        input logic [1:0] dig);
    seg_t s;
    s = glyph_of(num[{dig, 2'b00} +: 4]);
    // disabled digit
    if (!en[dig]) s = SEG_BLANK;
    // blink-selected digit in its dark phase
    if ((sel == {6'd0, dig}) && !blink_on) s = SEG_BLANK;
    return s;
  endfunction

  // register mirror following the bus write rules
  always @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      sh_number   <= '0;
      sh_en       <= '0;
      sh_sel      <= '0;
      prev_number <= '0;
      prev_en     <= '0;
      prev_sel    <= '0;
      edge_cnt    <= 64'd0;
    end else begin
      prev_number <= sh_number;
      prev_en     <= sh_en;
      prev_sel    <= sh_sel;
      edge_cnt    <= edge_cnt + 64'd1;
      if (we_i && addr_i[3] && be_i[2] && (wdata_i[23:16] != 8'h00)) begin
        // clear command beats every other lane
        sh_number <= 16'h0000;
        sh_en     <= 4'hF;
        sh_sel    <= 8'hFF;
      end else if (we_i && addr_i[3]) begin
        sh_en  <= be_i[0] ? wdata_i[3:0] : sh_en;
        sh_sel <= be_i[1] ? wdata_i[15:8] : sh_sel;
      end else if (we_i) begin
        sh_number[7:0]  <= be_i[0] ? wdata_i[7:0] : sh_number[7:0];
        sh_number[15:8] <= be_i[1] ? wdata_i[15:8] : sh_number[15:8];
      end
    end
  end

  // pins sampled on the falling edge
  always @(negedge clk_i) begin : check_display
    logic [63:0] slot;
    logic [63:0] half;
    logic [1:0]  dig;
    logic [1:0]  exp_dig;
    int          n_low;
    seg_t        exp_seg;
    n_low = 0;
    dig   = 2'd0;
    for (int i = 0; i < 4; i++) begin
      if (!dut_an_i[i]) begin
        n_low++;
        dig = 2'(i);
      end
    end
    if (rst_i || (edge_cnt == 64'd0)) begin
      // dark until the first slot
      if (dut_an_i !== 4'hF) begin
        $display("Mismatch an_o: expected %h, got %h at %0t", 4'hF, dut_an_i, $time);
        err_cnt++;
      end
      if (dut_seg_i !== SEG_BLANK) begin
        $display("Mismatch seg_o: expected %h, got %h at %0t", SEG_BLANK, dut_seg_i, $time);
        err_cnt++;
      end
    end else if (n_low != 1) begin
      $display("Error: an_o does not select exactly one digit at %0t", $time);
      err_cnt++;
    end else begin
      // pins show the counters as they were one clock ago
      slot    = (edge_cnt - 64'd1) / SLOT_CYCLES;
      half    = (edge_cnt - 64'd1) / BLINK_CYCLES;
      exp_dig = slot[1:0];
      if (dig != exp_dig) begin
        $display("Mismatch an_o: expected %h, got %h at %0t",
                 ~(4'b0001 << exp_dig), dut_an_i, $time);
        err_cnt++;
      end
      exp_seg = expected_seg(prev_number, prev_en, prev_sel, half[0], exp_dig);
      cmp_cnt++;
      if (dut_seg_i !== exp_seg) begin
        $display("Mismatch seg_o: digit %0d expected %h, got %h at %0t",
                 exp_dig, exp_seg, dut_seg_i, $time);
        err_cnt++;
      end
    end
  end

endmodule

/* test/tb_hex_ctrl.sv */
`timescale 1ns/10ps
`include "hex_settings.svh"

module tb_hex_ctrl;

  import hex_pkg::*;

  localparam longint SCAN_CYCLES  = 4 * (2 ** (`HEX_REFRESH_BITS - 2));
  localparam longint BLINK_CYCLES = `HEX_BLINK_CYCLES;
  localparam int     N_RANDOM     = 200;
  // one write step is the write, two readbacks and a full scan
  localparam longint STEP_CYCLES  = SCAN_CYCLES + 6;
  // reset, 19 write steps, five blink steps and the random writes
  localparam longint RUN_CYCLES   = (2 * SCAN_CYCLES + 8) + 19 * STEP_CYCLES
                                  + 5 * (2 * BLINK_CYCLES + STEP_CYCLES)
                                  + 4 * N_RANDOM + SCAN_CYCLES;
  // budget with a 20 percent margin at 10 ns per clock
  localparam longint WATCHDOG_NS  = RUN_CYCLES * 12 / 10 * 10;

  logic        clk_i = 1'b0;
  logic        rst_i;
  logic [31:0] wdata_i;
  logic [31:0] addr_i;
  logic [3:0]  be_i;
  logic        we_i;
  logic [6:0]  seg_o;
  logic [3:0]  an_o;
  logic [31:0] out_o;
  int          chk_errs;
  int          chk_cmps;

  // expected register state
  number_t     m_number;
  dig_mask_t   m_en;
  blink_sel_t  m_sel;
  logic [31:0] lcg_state;
  int          tb_errs;
  int          test_no;
  int          test_start_errs;
  int          n_pass;
  int          n_fail;

  hex_ctrl u_dut (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .wdata_i (wdata_i),
    .addr_i  (addr_i),
    .be_i    (be_i),
    .we_i    (we_i),
    .seg_o   (seg_o),
    .an_o    (an_o),
    .out_o   (out_o)
  );

  hex_checker u_chk (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wdata_i   (wdata_i),
    .addr_i    (addr_i),
    .be_i      (be_i),
    .we_i      (we_i),
    .dut_seg_i (seg_o),
    .dut_an_i  (an_o),
    .err_cnt_o (chk_errs),
    .cmp_cnt_o (chk_cmps)
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // upper halves only since the low LCG bits have short periods
  task automatic rand_word(output logic [31:0] r);
    lcg_state = lcg_next(lcg_state);
    r[31:16]  = lcg_state[31:16];
    lcg_state = lcg_next(lcg_state);
    r[15:0]   = lcg_state[31:16];
  endtask

  // readback word for either register
  function automatic logic [31:0] expected_out(input logic ctrl, input number_t num,
                                               input dig_mask_t en, input blink_sel_t sel);
    if (ctrl) return {16'h0000, sel, 4'h0, en};
    return {16'h0000, num};
  endfunction

  task automatic model_write(input logic ctrl, input logic [3:0] be, input logic [31:0] d);
    if (ctrl && be[2] && (d[23:16] != 8'h00)) begin
      m_number = 16'h0000;
      m_en     = 4'hF;
      m_sel    = 8'hFF;
    end else if (ctrl) begin
      m_en  = be[0] ? d[3:0] : m_en;
      m_sel = be[1] ? d[15:8] : m_sel;
    end else begin
      m_number[7:0]  = be[0] ? d[7:0] : m_number[7:0];
      m_number[15:8] = be[1] ? d[15:8] : m_number[15:8];
    end
  endtask

  // write lands on the second edge and addr_i is held afterwards
  task automatic write_reg(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data);
    @(posedge clk_i);
    addr_i  <= addr;
    be_i    <= be;
    wdata_i <= data;
    we_i    <= 1'b1;
    @(posedge clk_i);
    we_i    <= 1'b0;
    model_write(addr[3], be, data);
  endtask

  task automatic compare_out();
    logic [31:0] exp_out;
    @(negedge clk_i);
    exp_out = expected_out(addr_i[3], m_number, m_en, m_sel);
    if (out_o !== exp_out) begin
      $display("Mismatch out_o: addr %h expected %h, got %h", addr_i, exp_out, out_o);
      tb_errs++;
    end
  endtask

  task automatic read_check(input logic [31:0] addr);
    @(posedge clk_i);
    addr_i <= addr;
    compare_out();
  endtask

  // write, read back both registers and let one scan go by
  task automatic write_step(input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] data);
    write_reg(addr, be, data);
    compare_out();
    read_check(addr ^ 32'h0000_0008);
    repeat (SCAN_CYCLES) @(posedge clk_i);
  endtask

  // one selection held for two blink half-periods
  task automatic blink_step(input blink_sel_t sel);
    write_reg(32'h0000_0008, 4'b0010, {16'h0000, sel, 8'h00});
    compare_out();
    repeat (2 * BLINK_CYCLES + SCAN_CYCLES) @(posedge clk_i);
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = tb_errs + chk_errs - test_start_errs;
    test_no++;
    if (errs == 0) begin
      n_pass++;
      $display("test %0d %s: ok", test_no, name);
    end else begin
      n_fail++;
      $display("test %0d %s: %0d errors", test_no, name, errs);
    end
    test_start_errs = tb_errs + chk_errs;
  endtask

  initial begin
    logic [31:0] r_addr;
    logic [31:0] r_data;
    logic [31:0] r_be;
    rst_i           <= 1'b1;
    we_i            <= 1'b0;
    be_i            <= 4'h0;
    addr_i          <= 32'h0;
    wdata_i         <= 32'h0;
    lcg_state       = 32'd85894;
    m_number        = '0;
    m_en            = '0;
    m_sel           = '0;
    tb_errs         = 0;
    test_no         = 0;
    test_start_errs = 0;
    n_pass          = 0;
    n_fail          = 0;
    repeat (2) @(posedge clk_i);
    rst_i <= 1'b0;

    // reset values with enable 0 keep every digit dark
    compare_out();
    read_check(32'h0000_0008);
    repeat (2 * SCAN_CYCLES) @(posedge clk_i);
    end_test("reset state");

    // all digits on and steady before each lane mix
    write_step(32'h0000_0008, 4'b0011, 32'h0000_FF0F);
    write_step(32'h0000_0000, 4'b0011, 32'h0000_1234);
    write_step(32'h0000_0000, 4'b0001, 32'h1111_11AB);
    write_step(32'h0000_0000, 4'b0010, 32'h0000_CD00);
    write_step(32'h0000_0000, 4'b0000, 32'hFFFF_FFFF);
    write_step(32'h0000_0000, 4'b1100, 32'hFFFF_FFFF);
    end_test("number writes");

    // enable and blink lanes with upper address bits ignored
    write_step(32'h0000_0008, 4'b0011, 32'h0000_7F05);
    write_step(32'h0000_0008, 4'b0001, 32'hFFFF_FFFA);
    write_step(32'h0000_0008, 4'b0010, 32'h0000_8000);
    write_step(32'h0000_0008, 4'b1011, 32'h00A5_C306);
    write_step(32'h1234_5678, 4'b0001, 32'h0000_0009);
    write_step(32'h0000_0004, 4'b0011, 32'h0000_9876);
    end_test("control writes");

    // each digit blinks in turn and FF holds still
    write_step(32'h0000_0008, 4'b0001, 32'h0000_000F);
    for (int k = 0; k < 4; k++) begin
      blink_step(8'(k));
    end
    blink_step(8'hFF);
    end_test("blink");

    // clear alone, zero lane 2 and clear with every lane
    write_step(32'h0000_0000, 4'b0011, 32'h0000_5A5A);
    write_step(32'h0000_0008, 4'b0100, 32'h0001_0000);
    write_step(32'h0000_0008, 4'b0011, 32'h0000_0103);
    write_step(32'h0000_0008, 4'b0111, 32'h0000_0203);
    write_step(32'h0000_0008, 4'b1111, 32'hFF80_0400);
    write_step(32'h0000_0000, 4'b0111, 32'h00FF_4321);
    end_test("clear command");

    for (int i = 0; i < N_RANDOM; i++) begin
      rand_word(r_addr);
      rand_word(r_data);
      rand_word(r_be);
      write_reg(r_addr, r_be[3:0], r_data);
      compare_out();
      read_check(r_addr ^ 32'h0000_0008);
    end
    repeat (SCAN_CYCLES) @(posedge clk_i);
    end_test("random writes");

    if (chk_cmps == 0) begin
      $display("Error: the checker never compared the display");
      tb_errs++;
    end
    $display("summary: %0d tests ok, %0d tests with errors, %0d display compares, %0d errors",
             n_pass, n_fail, chk_cmps, tb_errs + chk_errs);
    if ((n_fail == 0) && ((tb_errs + chk_errs) == 0)) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // run budget from the timing macros
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule
